// ==== verilog/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // Basic widths
    typedef logic [15:0] word_t;        // Register, address, operand
    typedef logic [7:0]  byte_t;        // Bus byte
    typedef logic [2:0]  regSel_t;      // AX CX DX BX SP BP SI DI
    typedef logic [11:0] flags_t;       // 8086 flag word layout

    // ALU ops in opcode bits 5:3 order
    typedef enum logic [2:0] {
        ADD = 3'd0,
        OR  = 3'd1,
        ADC = 3'd2,
        SBB = 3'd3,
        AND = 3'd4,
        SUB = 3'd5,
        XOR = 3'd6,
        CMP = 3'd7
    } aluOp_t;

    typedef enum logic [1:0] {FETCH, MODRM, EXEC} seqState_t;

    // Opcode and ModRM fields --------------------
    localparam int wBit   = 0;          // Width bit of ALU opcodes
    localparam int dBit   = 1;          // Direction bit, 1 = reg is destination
    localparam int aluLo  = 3;          // ALU op field, 3 bits
    localparam int rmLo   = 0;          // ModRM rm field
    localparam int regLo  = 3;          // ModRM reg field
    localparam int modLo  = 6;          // ModRM mod field, 2 bits

    // Flag positions --------------------
    localparam int cfBit = 0;
    localparam int pfBit = 2;
    localparam int afBit = 4;
    localparam int zfBit = 6;
    localparam int sfBit = 7;
    localparam int ofBit = 11;

    localparam regSel_t regAx = 3'd0;
    localparam regSel_t regSp = 3'd4;
    localparam flags_t  flagsReset = 12'h002;   // Bit 1 always reads as one

endpackage

`default_nettype wire

// ==== verilog/aluCore.sv ====
`default_nettype none
`timescale 1ns/1ns

module aluCore import cpuPkg::*; (
    input  wire word_t   op1,
    input  wire word_t   op2,
    input  wire aluOp_t  aluOp,
    input  wire          wide,
    input  wire          carryIn,
    input  wire flags_t  flagsIn,
    output word_t        result,
    output flags_t       flagsOut
);

    logic [16:0] sum;           // Carry or borrow in the top bit of the used width
    logic isAdd, isSub, cin;
    logic sign1, sign2, signR, carry, zero;
    logic ovfAdd, ovfSub;

    assign isAdd = (aluOp == ADD) || (aluOp == ADC);
    assign isSub = (aluOp == SUB) || (aluOp == SBB) || (aluOp == CMP);
    assign cin   = carryIn && ((aluOp == ADC) || (aluOp == SBB));

    always_comb begin
        case (aluOp)
            ADD, ADC:      sum = {1'b0, op1} + {1'b0, op2} + {16'h0000, cin};
            SUB, SBB, CMP: sum = {1'b0, op1} - {1'b0, op2} - {16'h0000, cin};
            OR:            sum = {1'b0, op1 | op2};
            AND:           sum = {1'b0, op1 & op2};
            default:       sum = {1'b0, op1 ^ op2};   // XOR
        endcase
    end

    assign result = wide ? sum[15:0] : {8'h00, sum[7:0]};

    // Width select --------------------
    // Byte operands arrive zero extended so bit 8 is the byte carry
    assign sign1 = wide ? op1[15] : op1[7];
    assign sign2 = wide ? op2[15] : op2[7];
    assign signR = wide ? sum[15] : sum[7];
    assign carry = wide ? sum[16] : sum[8];
    assign zero  = wide ? (sum[15:0] == 16'h0000) : (sum[7:0] == 8'h00);

    assign ovfAdd = (sign1 == sign2) && (signR != sign1);  // Like signs, new sign
    assign ovfSub = (sign1 != sign2) && (signR != sign1);

    always_comb begin
        flagsOut        = flagsIn;          // DF IF TF ride along
        flagsOut[cfBit] = (isAdd || isSub) && carry;
        flagsOut[1]     = 1'b1;
        flagsOut[pfBit] = ~^sum[7:0];       // Even parity of the low byte
        flagsOut[3]     = 1'b0;
        flagsOut[afBit] = (isAdd || isSub) ? (op1[4] ^ op2[4] ^ sum[4]) : sum[4];
        flagsOut[5]     = 1'b0;
        flagsOut[zfBit] = zero;
        flagsOut[sfBit] = signR;
        if (isAdd)
            flagsOut[ofBit] = ovfAdd;
        else if (isSub)
            flagsOut[ofBit] = ovfSub;
        else
            flagsOut[ofBit] = 1'b0;         // Logic ops
    end

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`default_nettype none
`timescale 1ns/1ns

module regFile import cpuPkg::*; #(
    parameter word_t resetSp = 16'h0100
) (
    input  wire          clk25,
    input  wire          rst,
    input  wire regSel_t rdSel,
    input  wire          wide,
    input  wire regSel_t wrSel,
    input  wire          wrWide,
    input  wire word_t   wrData,
    input  wire          wrEn,
    output word_t        readData,
    output word_t        spValue
);

    word_t regs [8];            // AX CX DX BX SP BP SI DI

    assign spValue = regs[regSp];

    // Byte numbers 4..7 are AH CH DH BH
    always_comb begin
        if (wide)
            readData = regs[rdSel];
        else if (rdSel[2])
            readData = {8'h00, regs[{1'b0, rdSel[1:0]}][15:8]};
        else
            readData = {8'h00, regs[rdSel][7:0]};   // Zero extended
    end

    // Write-back --------------------
    always_ff @(posedge clk25) begin
        if (rst) begin
            for (int k = 0; k < 8; k++) begin
                regs[k] <= (regSel_t'(k) == regSp) ? resetSp : 16'h0000;
            end
        end else if (wrEn) begin
            if (wrWide)
                regs[wrSel] <= wrData;
            else if (wrSel[2])
                regs[{1'b0, wrSel[1:0]}][15:8] <= wrData[7:0];  // High half alias
            else
                regs[wrSel][7:0] <= wrData[7:0];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pushWriter.sv ====
`default_nettype none
`timescale 1ns/1ns

module pushWriter import cpuPkg::*; (
    input  wire          clk25,
    input  wire          rst,
    input  wire          pushReq,
    input  wire word_t   pushData,
    input  wire word_t   spValue,
    input  wire word_t   ip,
    output word_t        a,
    output byte_t        o,
    output logic         w,
    output logic         pushBusy,
    output logic         spWrEn,
    output word_t        spWrData
);

    typedef enum logic [1:0] {pwIdle, pwLow, pwHigh, pwGap} pushState_t;

    pushState_t state;
    word_t      addr;           // Current stack byte address
    word_t      data;           // Word being pushed

    // Bus outputs --------------------
    assign w        = (state == pwLow) || (state == pwHigh);
    assign a        = w ? addr : ip;            // Code fetch address otherwise
    assign o        = (state == pwHigh) ? data[15:8] : data[7:0];
    assign pushBusy = state != pwIdle;
    assign spWrEn   = state == pwLow;           // SP = SP - 2 in the first byte cycle
    assign spWrData = addr;

    always_ff @(posedge clk25) begin
        if (rst) begin
            state <= pwIdle;
        end else begin
            case (state)
                pwIdle: if (pushReq) begin
                    addr  <= spValue - 16'd2;
                    data  <= pushData;
                    state <= pwLow;
                end
                pwLow: begin
                    addr  <= addr + 16'd1;      // High byte above the low one
                    state <= pwHigh;
                end
                pwHigh: state <= pwGap;
                default: state <= pwIdle;       // Gap cycle with w low
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/execSequencer.sv ====
`default_nettype none
`timescale 1ns/1ns

module execSequencer import cpuPkg::*; #(
    parameter word_t resetIp = 16'hFFF0
) (
    input  wire          clk25,
    input  wire          rst,
    input  wire byte_t   i,
    input  wire word_t   readData,
    input  wire word_t   result,
    input  wire flags_t  flagsOut,
    input  wire          pushBusy,
    input  wire word_t   spValue,
    output word_t        ip,
    output regSel_t      rdSel,
    output logic         wide,
    output regSel_t      wrSel,
    output word_t        wrData,
    output logic         wrEn,
    output aluOp_t       aluOp,
    output word_t        op1,       // Destination
    output word_t        op2,       // Source
    output logic         carryIn,
    output flags_t       flags,
    output logic         pushReq,
    output word_t        pushData
);

    seqState_t state;
    byte_t     opcode, modrm;
    logic [1:0] micro;              // Step inside MODRM or EXEC
    logic      wideR;               // 0 = byte, 1 = word
    logic      dir;                 // Direction bit of the opcode
    regSel_t   selR;                // Register of the current instruction
    logic      regForm;             // mod = 11
    logic      isPush;
    flags_t    incFlags;

    assign regForm = modrm[modLo +: 2] == 2'b11;
    assign isPush  = (state == FETCH) && !pushBusy && (i[7:3] == 5'b01010);
    assign carryIn = flags[cfBit];
    assign wide    = (state == FETCH) ? 1'b1 : wideR;   // PUSH reads a full word

    // INC and DEC leave CF alone
    always_comb begin
        incFlags        = flagsOut;
        incFlags[cfBit] = flags[cfBit];
    end

    // Register selects and write-back --------------------
    always_comb begin
        rdSel    = selR;
        wrSel    = selR;
        wrData   = result;
        wrEn     = 1'b0;
        pushReq  = isPush;
        pushData = readData;            // Value before the SP decrement
        case (state)
            FETCH: rdSel = i[2:0];      // PUSH register straight from the opcode
            MODRM: rdSel = (micro == 2'd0) ? i[regLo +: 3] : modrm[rmLo +: 3];
            default: casez (opcode)
                8'b00???0??: begin      // ALU r/m, reg
                    wrSel = dir ? modrm[regLo +: 3] : modrm[rmLo +: 3];
                    wrEn  = regForm && (aluOp != CMP);  // CMP keeps the destination
                end
                8'b00???10?: wrEn = (micro == 2'd2) && (aluOp != CMP);
                8'b1011????: begin      // MOV reg, imm
                    wrData = wideR ? {i, op2[7:0]} : {8'h00, i};
                    wrEn   = !wideR || (micro == 2'd1);
                end
                8'b0100????: wrEn = micro == 2'd1;      // INC/DEC result
                default: ;
            endcase
        endcase
    end

    // Main sequencer --------------------
    always_ff @(posedge clk25) begin
        if (rst) begin
            state <= FETCH;
            ip    <= resetIp;
            flags <= flagsReset;
            micro <= 2'd0;
        end else begin
            case (state)
                FETCH: if (!pushBusy) begin     // Hold while the bus writer runs
                    opcode <= i;
                    micro  <= 2'd0;
                    ip     <= ip + 16'd1;
                    casez (i)
                        8'b00???0??: begin      // ALU with ModRM
                            aluOp <= aluOp_t'(i[aluLo +: 3]);
                            wideR <= i[wBit];
                            dir   <= i[dBit];
                            state <= MODRM;
                        end
                        8'b00???10?: begin      // ALU AL/AX, imm
                            aluOp <= aluOp_t'(i[aluLo +: 3]);
                            wideR <= i[wBit];
                            selR  <= regAx;
                            state <= EXEC;
                        end
                        8'b1011????: begin      // MOV reg, imm8/imm16
                            wideR <= i[3];
                            selR  <= i[2:0];
                            state <= EXEC;
                        end
                        8'b0100????: begin      // INC/DEC r16
                            aluOp <= i[3] ? SUB : ADD;
                            wideR <= 1'b1;
                            selR  <= i[2:0];
                            op2   <= 16'h0001;
                            state <= EXEC;
                        end
                        8'b111010?1: state <= EXEC;             // JMP near or short
                        8'b11110101: flags[cfBit] <= ~flags[cfBit]; // CMC
                        8'b1111100?: flags[cfBit] <= i[0];      // CLC/STC
                        default: ;              // PUSH, NOP and the rest finish here
                    endcase
                end
                MODRM: begin
                    if (micro == 2'd0) begin    // ModRM byte plus reg operand
                        modrm <= i;
                        ip    <= ip + 16'd1;
                        micro <= 2'd1;
                        if (dir) op1 <= readData;
                        else     op2 <= readData;
                    end else begin              // rm operand
                        if (dir) op2 <= readData;
                        else     op1 <= readData;
                        state <= EXEC;
                    end
                end
                default: casez (opcode)
                    8'b00???0??: begin
                        if (regForm) flags <= flagsOut;
                        state <= FETCH;
                    end
                    8'b00???10?: case (micro)
                        2'd0: begin                 // Accumulator and low imm byte
                            op1   <= readData;
                            op2   <= {8'h00, i};
                            ip    <= ip + 16'd1;
                            micro <= wideR ? 2'd1 : 2'd2;
                        end
                        2'd1: begin                 // High imm byte
                            op2[15:8] <= i;
                            ip        <= ip + 16'd1;
                            micro     <= 2'd2;
                        end
                        default: begin
                            flags <= flagsOut;
                            state <= FETCH;
                        end
                    endcase
                    8'b1011????: begin
                        op2[7:0] <= i;              // Low byte kept for the word case
                        ip       <= ip + 16'd1;
                        micro    <= 2'd1;
                        if (!wideR || micro == 2'd1) state <= FETCH;
                    end
                    8'b0100????: begin
                        if (micro == 2'd0) begin
                            op1   <= readData;
                            micro <= 2'd1;
                        end else begin
                            flags <= incFlags;
                            state <= FETCH;
                        end
                    end
                    8'b111010?1: begin
                        if (opcode[1]) begin        // rel8
                            ip    <= ip + 16'd1 + {{8{i[7]}}, i};
                            state <= FETCH;
                        end else if (micro == 2'd0) begin
                            op2[7:0] <= i;
                            ip       <= ip + 16'd1;
                            micro    <= 2'd1;
                        end else begin              // rel16 complete
                            ip    <= ip + 16'd1 + {i, op2[7:0]};
                            state <= FETCH;
                        end
                    end
                    default: state <= FETCH;
                endcase
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cpuTop.sv ====
`default_nettype none
`timescale 1ns/1ns

module cpuTop import cpuPkg::*; #(
    parameter word_t resetIp = 16'hFFF0,
    parameter word_t resetSp = 16'h0100
) (
    input  wire          clk25,
    input  wire          rst,
    input  wire byte_t   i,         // Memory byte at address a
    output byte_t        o,         // Write data
    output word_t        a,         // Bus address
    output logic         w          // Write strobe
);

    // Sequencer side
    word_t   ip;
    regSel_t rdSel, wrSel;
    logic    seqWide, seqWrEn;
    word_t   seqWrData;
    aluOp_t  aluOp;
    word_t   op1, op2;
    logic    carryIn;
    flags_t  flags;
    logic    pushReq;
    word_t   pushData;

    // Register file, ALU and bus writer side
    word_t   readData, spValue, result;
    flags_t  flagsOut;
    logic    pushBusy, spWrEn;
    word_t   spWrData;

    // Register file write port ------------------
    // SP update from a push wins, sequencer is stalled then anyway
    regSel_t rfWrSel;
    logic    rfWrWide, rfWrEn;
    word_t   rfWrData;

    assign rfWrEn   = spWrEn | seqWrEn;
    assign rfWrSel  = spWrEn ? regSp : wrSel;
    assign rfWrWide = spWrEn | seqWide;        // SP always 16 bit
    assign rfWrData = spWrEn ? spWrData : seqWrData;

    execSequencer #(.resetIp(resetIp)) u_execSequencer (
        .clk25(clk25), .rst(rst), .i(i), .readData(readData), .result(result),
        .flagsOut(flagsOut), .pushBusy(pushBusy), .spValue(spValue), .ip(ip),
        .rdSel(rdSel), .wide(seqWide), .wrSel(wrSel), .wrData(seqWrData),
        .wrEn(seqWrEn), .aluOp(aluOp), .op1(op1), .op2(op2), .carryIn(carryIn),
        .flags(flags), .pushReq(pushReq), .pushData(pushData)
    );

    regFile #(.resetSp(resetSp)) u_regFile (
        .clk25(clk25), .rst(rst), .rdSel(rdSel), .wide(seqWide), .wrSel(rfWrSel),
        .wrWide(rfWrWide), .wrData(rfWrData), .wrEn(rfWrEn),
        .readData(readData), .spValue(spValue)
    );

    aluCore u_aluCore (
        .op1(op1), .op2(op2), .aluOp(aluOp), .wide(seqWide), .carryIn(carryIn),
        .flagsIn(flags), .result(result), .flagsOut(flagsOut)
    );

    pushWriter u_pushWriter (
        .clk25(clk25), .rst(rst), .pushReq(pushReq), .pushData(pushData),
        .spValue(spValue), .ip(ip), .a(a), .o(o), .w(w), .pushBusy(pushBusy),
        .spWrEn(spWrEn), .spWrData(spWrData)
    );

endmodule

`default_nettype wire

// ==== tests/cpuTop_assertions.sv ====
`default_nettype none
`timescale 1ns/1ns

module cpuTop_assertions import cpuPkg::*; (
    input  wire          clk25,
    input  wire          rst,
    input  wire word_t   a,
    input  wire          w,
    input  wire word_t   ip,
    input  wire          pushBusy
);

    // Bus quiet once reset has been seen
    assert property (@(posedge clk25) rst |=> !w)
        else $error("Write strobe high after a reset cycle");

    // Low byte then high byte one address up
    assert property (@(posedge clk25) disable iff (rst)
        $rose(w) |=> w && (a == $past(a) + 16'd1))
        else $error("Push bytes not at consecutive addresses");

    assert property (@(posedge clk25) disable iff (rst)
        w && $past(w) |=> !w)
        else $error("More than two write strobes in a row");

    // Fetch address is the IP
    assert property (@(posedge clk25) disable iff (rst) !pushBusy |-> a == ip)
        else $error("Bus address differs from IP outside a push");

endmodule

`default_nettype wire

// ==== tests/cpuChecker.sv ====
`default_nettype none
`timescale 1ns/1ns

module cpuChecker import cpuPkg::*; #(
    parameter word_t startIp  = 16'hFFF0,
    parameter word_t stackTop = 16'h0100
) (
    input  wire          clk25,
    input  wire          rst,
    input  wire word_t   a,
    input  wire byte_t   o,
    input  wire          w,
    input  wire          progReady,
    input  wire byte_t   prog [65536],
    output logic         done,
    output int           mismatchCount,
    output int           otherCount
);

    word_t       regs [8];                  // Model registers, AX first
    logic        cf;                        // Only flag that reaches a push
    logic [23:0] expWrites [$];             // Address above the data byte
    logic        built = 1'b0;
    int          expTotal = 0;
    int          seen = 0;
    int          mismatches = 0;
    int          others = 0;
    string       half;

    assign done          = built && (seen == expTotal);
    assign mismatchCount = mismatches;
    assign otherCount    = others;

    // Byte view AL CL DL BL AH CH DH BH
    function automatic word_t readReg(input regSel_t r, input logic wide);
        if (wide) return regs[r];
        if (r[2]) return {8'h00, regs[{1'b0, r[1:0]}][15:8]};
        return {8'h00, regs[r][7:0]};
    endfunction

    function automatic void writeReg(input regSel_t r, input logic wide, input word_t v);
        if (wide) regs[r] = v;
        else if (r[2]) regs[{1'b0, r[1:0]}][15:8] = v[7:0];
        else regs[r][7:0] = v[7:0];
    endfunction

    // Integer arithmetic, CF as carry beyond the width or borrow below zero
    function automatic word_t aluModel(input logic [2:0] op, input word_t x, input word_t y,
                                       input logic wide);
        int mask;
        int r;
        mask = wide ? 32'h0000FFFF : 32'h000000FF;
        case (op)
            3'd0: r = int'(x) + int'(y);
            3'd2: r = int'(x) + int'(y) + int'(cf);            // ADC
            3'd3: r = int'(x) - int'(y) - int'(cf);            // SBB
            3'd5, 3'd7: r = int'(x) - int'(y);                  // SUB, CMP
            3'd1: r = int'(x | y);
            3'd4: r = int'(x & y);
            default: r = int'(x ^ y);
        endcase
        cf = (op inside {3'd1, 3'd4, 3'd6}) ? 1'b0 : ((r < 0) || (r > mask));
        return word_t'(r & mask);
    endfunction

    // Instruction level run of the program --------------------
    task automatic runModel();
        word_t   pc;
        word_t   imm;
        word_t   v;
        byte_t   code;
        byte_t   modrm;
        regSel_t dst;
        logic    keepCf;
        logic    finished;
        int      steps;
        for (int k = 0; k < 8; k++) regs[k] = 16'h0000;
        regs[regSp] = stackTop;
        cf       = 1'b0;
        pc       = startIp;
        finished = 1'b0;
        steps    = 0;
        while (!finished && steps < 5000) begin
            code = prog[pc];
            pc   = pc + 16'd1;
            steps++;
            casez (code)
                8'b00???0??: begin
                    modrm = prog[pc];
                    pc    = pc + 16'd1;
                    dst   = code[1] ? modrm[5:3] : modrm[2:0];
                    v = aluModel(code[5:3], readReg(dst, code[0]),
                                 readReg(code[1] ? modrm[2:0] : modrm[5:3], code[0]), code[0]);
                    if (code[5:3] != 3'd7) writeReg(dst, code[0], v);
                end
                8'b00???10?, 8'b1011????: begin     // Immediate forms
                    imm = {8'h00, prog[pc]};
                    pc  = pc + 16'd1;
                    if (code[7] ? code[3] : code[0]) begin
                        imm[15:8] = prog[pc];
                        pc        = pc + 16'd1;
                    end
                    if (code[7]) begin
                        writeReg(code[2:0], code[3], imm);  // MOV
                    end else begin
                        v = aluModel(code[5:3], readReg(regAx, code[0]), imm, code[0]);
                        if (code[5:3] != 3'd7) writeReg(regAx, code[0], v);
                    end
                end
                8'b0100????: begin                  // INC/DEC keep CF
                    keepCf = cf;
                    regs[code[2:0]] = aluModel(code[3] ? 3'd5 : 3'd0, regs[code[2:0]],
                                               16'h0001, 1'b1);
                    cf = keepCf;
                end
                8'b01010???: begin                  // PUSH, old value, low byte first
                    v = regs[code[2:0]];
                    expWrites.push_back({regs[regSp] - 16'd2, v[7:0]});
                    expWrites.push_back({regs[regSp] - 16'd1, v[15:8]});
                    regs[regSp] = regs[regSp] - 16'd2;
                end
                8'hF8, 8'hF9: cf = code[0];
                8'hF5: cf = ~cf;
                8'hEB: begin
                    finished = prog[pc] == 8'hFE;   // Self loop ends the program
                    pc = pc + 16'd1 + {{8{prog[pc][7]}}, prog[pc]};
                end
                8'hE9: begin
                    imm = {prog[pc + 16'd1], prog[pc]};
                    pc  = pc + 16'd2 + imm;
                end
                default: ;
            endcase
        end
        expTotal = expWrites.size();
    endtask

    // Compare on the falling edge, bus outputs settled
    always @(negedge clk25) begin
        if (progReady && !built) begin
            runModel();
            built = 1'b1;
        end else if (built && !rst && w) begin
            if (seen >= expTotal) begin
                others++;
                $display("Unexpected bus write of %02h at %04h after the last push", o, a);
            end else begin
                half = (seen % 2 == 0) ? "low" : "high";
                if (expWrites[seen] != {a, o}) begin
                    mismatches++;
                    $display("FAILED push%0d_%s: expected %02h at %04h, actual %02h at %04h",
                             seen / 2, half, expWrites[seen][7:0], expWrites[seen][23:8], o, a);
                end
                seen++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tbTop.sv ====
`default_nettype none
`timescale 1ns/1ns

module tbTop import cpuPkg::*; ();

    localparam word_t startIp   = 16'hFFF0;
    localparam word_t stackTop  = 16'h0100;
    localparam int    blocks    = 24;       // Random program blocks
    localparam int    maxCycles = 20000;

    logic  clk25;
    logic  rst;
    byte_t i;
    byte_t o;
    word_t a;
    logic  w;

    byte_t       mem [65536];               // Program memory, read only
    logic        progReady;
    logic [15:0] lfsr;
    word_t       pc;                        // Emit pointer of the generator
    logic        done;
    int          mismatchCount;
    int          otherCount;
    int          cycles;
    logic        timedOut;

    // 8 ns period
    always begin
        clk25 = 1'b0;
        #4;
        clk25 = 1'b1;
        #4;
    end

    // Memory answers the address of the current cycle
    always @(posedge clk25) begin
        #1;
        i = mem[a];
    end

    cpuTop #(.resetIp(startIp), .resetSp(stackTop)) u_cpuTop (
        .clk25(clk25), .rst(rst), .i(i), .o(o), .a(a), .w(w)
    );

    cpuChecker #(.startIp(startIp), .stackTop(stackTop)) u_checker (
        .clk25(clk25), .rst(rst), .a(a), .o(o), .w(w), .progReady(progReady),
        .prog(mem), .done(done), .mismatchCount(mismatchCount), .otherCount(otherCount)
    );

    bind cpuTop cpuTop_assertions u_cpuTopAssertions (
        .clk25(clk25), .rst(rst), .a(a), .w(w), .ip(ip), .pushBusy(pushBusy)
    );

    // Random source --------------------
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);     // Galois taps 16 14 13 11
    endfunction

    function automatic logic takeBit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsrNext(lfsr);
        return b;
    endfunction

    function automatic logic [15:0] takeBits(input int n);
        logic [15:0] v;
        v = 16'h0000;
        for (int k = 0; k < n; k++) begin
            v = {v[14:0], takeBit()};
        end
        return v;
    endfunction

    function automatic regSel_t destReg(input logic wide);
        regSel_t r;
        r = regSel_t'(takeBits(3));
        if (wide && r == regSp)
            r = 3'd5;                       // Leave SP to the pushes
        return r;
    endfunction

    task automatic emit(input byte_t b);
        mem[pc] = b;
        pc      = pc + 16'd1;
    endtask

    // Program generator --------------------
    task automatic buildProgram();
        logic       wide;
        logic       dir;
        logic [2:0] kind;
        logic [2:0] op;
        regSel_t    dst;
        regSel_t    src;
        int         nOps;
        int         nFill;
        for (int k = 0; k < 65536; k++) begin
            mem[word_t'(k)] = byte_t'(k ^ (k >> 8));
        end
        pc = startIp;
        for (int b = 0; b < blocks; b++) begin
            for (int m = 0; m < 2; m++) begin      // MOV reg, imm
                wide = takeBit();
                dst  = destReg(wide);
                emit({4'b1011, wide, dst});
                emit(byte_t'(takeBits(8)));
                if (wide) emit(byte_t'(takeBits(8)));
            end
            nOps = 1 + int'(takeBits(2));
            for (int n = 0; n < nOps; n++) begin
                kind = 3'(takeBits(3));
                op   = 3'(takeBits(3));
                wide = takeBit();
                case (kind)
                    3'd0, 3'd1, 3'd2: begin         // ALU reg, reg
                        dir = takeBit();
                        dst = destReg(wide);
                        src = regSel_t'(takeBits(3));
                        emit({2'b00, op, 1'b0, dir, wide});
                        emit(dir ? {2'b11, dst, src} : {2'b11, src, dst});
                    end
                    3'd3, 3'd4: begin               // AL or AX with immediate
                        emit({2'b00, op, 2'b10, wide});
                        emit(byte_t'(takeBits(8)));
                        if (wide) emit(byte_t'(takeBits(8)));
                    end
                    3'd5: emit({4'b0100, op[0], destReg(1'b1)});       // INC or DEC
                    3'd6: emit(op[1] ? 8'hF5 : {7'b1111100, op[0]});   // CMC CLC STC
                    default: emit(8'h90);
                endcase
            end
            if (takeBit()) begin                    // Forward JMP over filler
                nFill = 1 + int'(takeBits(3));
                if (takeBit()) begin
                    emit(8'hEB);
                    emit(byte_t'(nFill));
                end else begin
                    emit(8'hE9);
                    emit(byte_t'(nFill));
                    emit(8'h00);
                end
                for (int f = 0; f < nFill; f++) emit(byte_t'(takeBits(8)));
            end
            emit({5'b01010, regSel_t'(takeBits(3))});   // PUSH r16
        end
        emit(8'hEB);                                // Park on JMP to itself
        emit(8'hFE);
    endtask

    initial begin
        rst       = 1'b1;
        i         = 8'h00;
        progReady = 1'b0;
        lfsr      = 16'd84;
        timedOut  = 1'b0;
        cycles    = 0;
        buildProgram();
        progReady = 1'b1;
        repeat (4) @(posedge clk25);
        #1 rst = 1'b0;
        while (!done && !timedOut) begin
            @(posedge clk25);
            cycles++;
            if (cycles >= maxCycles) timedOut = 1'b1;
        end
        if (timedOut)
            $display("Timeout: expected push writes still missing after %0d cycles", cycles);
        else
            repeat (16) @(posedge clk25);          // Catch stray writes
        $display("Errors: %0d value mismatches, %0d other failures",
                 mismatchCount, otherCount + int'(timedOut));
        if (mismatchCount == 0 && otherCount == 0 && !timedOut)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/cpuPkg.sv
verilog/aluCore.sv
verilog/regFile.sv
verilog/pushWriter.sv
verilog/execSequencer.sv
verilog/cpuTop.sv
tests/cpuTop_assertions.sv
tests/cpuChecker.sv
tests/tbTop.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the cpuTop regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns --top-module tbTop \
    --Mdir obj_dir -f list.f > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/VtbTop > sim.log 2>&1 || echo "Simulation ended with an error status" >> sim.log
cat sim.log
! grep -q "Regression failed" sim.log && grep -q "Regression passed" sim.log
